// File: fetch_pkg.sv
////////////////////////////////////////
// core-side types of the fetch stage
// import into any module that handles the fetch pc,
// instruction words or the packet sent to decode
////////////////////////////////////////
`default_nettype none

package fetch_pkg;

    // rv64 byte address width
    localparam int unsigned ADDR_W = 64;
    // base isa only, no compressed words
    localparam int unsigned INSTR_W = 32;

    // pc value after reset, start of dram
    localparam logic [ADDR_W-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // one raw instruction word
    typedef logic [INSTR_W-1:0] instr_t;

    // packet handed to decode
    // pc in the upper 64 bits, instruction in the lower 32
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    // pc redirect coming back from execute
    // target must be word aligned
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

endpackage : fetch_pkg

`default_nettype wire

// File: mem_bus_pkg.sv
////////////////////////////////////////
// memory-side types of the icache port
// line refills use a valid/ready request
// and return one full line per handshake
////////////////////////////////////////
`default_nettype none

package mem_bus_pkg;

    // the request address reuses the core address type
    import fetch_pkg::*;

    // 16-byte line, four instruction words
    localparam int unsigned LINE_W = 128;
    // byte offset bits inside one line
    localparam int unsigned LINE_OFFSET_BITS = 4;

    // lowest address word sits in bits [31:0]
    typedef logic [LINE_W-1:0] line_t;

    // refill request toward memory
    // addr is line aligned, low offset bits zero
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

endpackage : mem_bus_pkg

`default_nettype wire

// File: pc_gen.sv
////////////////////////////////////////
// fetch program counter
// steps by one word per emitted packet,
// loads the execute target on a redirect
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module pc_gen
    import fetch_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    // redirect from execute, sampled at the edge
    input  wire redirect_t redirect_i,
    // high when a packet left toward decode this cycle
    input  wire logic      advance_i,
    output addr_t          pc_o
);

    // current fetch pc
    addr_t pc_q;
    // sequential successor, one word ahead
    addr_t pc_next_seq;

    // no compressed words, so always +4
    assign pc_next_seq = pc_q + addr_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (redirect_i.valid) begin
            // redirect wins over a step in the same cycle
            // (the controller blocks emission then anyway)
            pc_q <= redirect_i.target;
        end else if (advance_i) begin
            pc_q <= pc_next_seq;
        end
    end

    // pc goes straight to the arrays and the controller
    assign pc_o = pc_q;

endmodule : pc_gen

`default_nettype wire

// File: icache_arrays.sv
////////////////////////////////////////
// direct-mapped icache storage
// valid bits, tags and 16-byte lines with a
// combinational hit and word select by addr_i
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module icache_arrays
    import fetch_pkg::*;
    import mem_bus_pkg::*;
#(
    // power of two, at least 2
    parameter int unsigned NUM_LINES = 16
) (
    input  wire logic   clk,
    input  wire logic   rst,
    // lookup address, also the fill address while fill_i is high
    input  wire addr_t  pc_i,
    input  wire logic   fill_i,
    input  wire line_t  fill_line_i,
    output logic        hit_o,
    output instr_t      instr_o
);

    localparam int unsigned INDEX_W = $clog2(NUM_LINES);
    localparam int unsigned TAG_W   = ADDR_W - INDEX_W - LINE_OFFSET_BITS;

    // address fields
    logic [INDEX_W-1:0]            index;
    logic [TAG_W-1:0]              tag;
    logic [LINE_OFFSET_BITS-3:0]   word_sel;

    // storage
    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_W-1:0]     tag_q  [NUM_LINES];
    line_t                data_q [NUM_LINES];

    // line read at the current index
    line_t rd_line;

    assign index    = pc_i[LINE_OFFSET_BITS +: INDEX_W];
    assign tag      = pc_i[ADDR_W-1 -: TAG_W];
    assign word_sel = pc_i[LINE_OFFSET_BITS-1:2];

    // only the valid bits see reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[index] <= 1'b1;
        end
    end

    // tag and line written together on a fill
    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[index]  <= tag;
            data_q[index] <= fill_line_i;
        end
    end

    // hit needs both a valid line and a matching tag
    assign hit_o   = valid_q[index] && (tag_q[index] == tag);
    assign rd_line = data_q[index];
    // lowest address word lives in the low bits
    assign instr_o = rd_line[word_sel*INSTR_W +: INSTR_W];

endmodule : icache_arrays

`default_nettype wire

// File: icache_ctrl.sv
////////////////////////////////////////
// icache lookup/refill controller
// decides when a packet goes out, holds the
// refill request and pulses the line write
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module icache_ctrl
    import fetch_pkg::*;
    import mem_bus_pkg::*;
#(
    // must match the arrays
    parameter int unsigned NUM_LINES = 16
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire addr_t pc_i,
    input  wire logic  hit_i,
    input  wire logic  credit_avail_i,
    input  wire logic  redirect_valid_i,
    // refill port
    output mem_req_t   mem_req_o,
    input  wire logic  mem_ready_i,
    // line write enable toward the arrays
    output logic       fill_o,
    // pc step enable
    output logic       advance_o,
    output logic       fetch_valid_o
);

    localparam int unsigned INDEX_W = $clog2(NUM_LINES);
    localparam int unsigned TAG_W   = ADDR_W - INDEX_W - LINE_OFFSET_BITS;

    typedef enum logic {
        LOOKUP,
        REFILL
    } state_e;

    state_e state_q;
    state_e state_d;

    // missed line, kept as tag and index fields
    logic [TAG_W-1:0]   miss_tag_q;
    logic [INDEX_W-1:0] miss_index_q;

    logic in_lookup;
    logic start_refill;

    assign in_lookup = (state_q == LOOKUP);

    // emit on a hit with a free decode slot
    // a redirect cycle never emits, the pc is about to change
    assign fetch_valid_o = in_lookup && hit_i && credit_avail_i && !redirect_valid_i;
    assign advance_o     = fetch_valid_o;

    // miss on a pc that is being redirected is stale, skip it
    assign start_refill = in_lookup && !hit_i && !redirect_valid_i;

    // line lands on the ready edge
    assign fill_o = (state_q == REFILL) && mem_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            LOOKUP: begin
                if (start_refill) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // redirects do not abort a refill
                if (mem_ready_i) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    // miss address captured once, held for the whole refill
    always_ff @(posedge clk) begin
        if (start_refill) begin
            miss_tag_q   <= pc_i[ADDR_W-1 -: TAG_W];
            miss_index_q <= pc_i[LINE_OFFSET_BITS +: INDEX_W];
        end
    end

    // request stays up through REFILL, drops after the handshake edge
    always_comb begin
        mem_req_o.valid = (state_q == REFILL);
        mem_req_o.addr  = {miss_tag_q, miss_index_q, {LINE_OFFSET_BITS{1'b0}}};
    end

endmodule : icache_ctrl

`default_nettype wire

// File: fetch_credit_counter.sv
////////////////////////////////////////
// decode credit counter
// one credit per free decode buffer slot
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module fetch_credit_counter #(
    // decode buffer depth
    parameter int unsigned CREDITS = 2
) (
    input  wire logic clk,
    input  wire logic rst,
    // packet sent this cycle
    input  wire logic consume_i,
    // decode freed a slot this cycle
    input  wire logic return_i,
    output logic      credit_avail_o
);

    localparam int unsigned CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] count_q;

    // decode never returns more than it got,
    // and consume only happens with a free credit
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= CNT_W'(CREDITS);
        end else if (consume_i && !return_i) begin
            count_q <= count_q - 1'b1;
        end else if (return_i && !consume_i) begin
            count_q <= count_q + 1'b1;
        end
        // both or neither leaves the count alone
    end

    assign credit_avail_o = (count_q != '0);

endmodule : fetch_credit_counter

`default_nettype wire

// File: ifetch_top.sv
////////////////////////////////////////
// instruction fetch stage top
// pc, icache, refill port and decode credits;
// set NUM_LINES and CREDITS here
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module ifetch_top
    import fetch_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter int unsigned NUM_LINES = 16,
    parameter int unsigned CREDITS   = 2
) (
    input  wire logic      clk,
    input  wire logic      rst,
    // core side
    input  wire redirect_t redirect_i,
    input  wire logic      credit_return_i,
    output fetch_pkt_t     fetch_o,
    output logic           fetch_valid_o,
    // memory side
    output mem_req_t       mem_req_o,
    input  wire logic      mem_ready_i,
    input  wire line_t     mem_rdata_i
);

    addr_t  pc;
    addr_t  array_addr;
    instr_t instr;
    logic   hit;
    logic   fill;
    logic   advance;
    logic   credit_avail;

    pc_gen pc_gen_i (
        .clk        (clk),
        .rst        (rst),
        .redirect_i (redirect_i),
        .advance_i  (advance),
        .pc_o       (pc)
    );

    // a redirect may move the pc mid-refill,
    // so the line is written at the request address
    assign array_addr = fill ? mem_req_o.addr : pc;

    icache_arrays #(
        .NUM_LINES (NUM_LINES)
    ) icache_arrays_i (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (array_addr),
        .fill_i      (fill),
        .fill_line_i (mem_rdata_i),
        .hit_o       (hit),
        .instr_o     (instr)
    );

    icache_ctrl #(
        .NUM_LINES (NUM_LINES)
    ) icache_ctrl_i (
        .clk              (clk),
        .rst              (rst),
        .pc_i             (pc),
        .hit_i            (hit),
        .credit_avail_i   (credit_avail),
        .redirect_valid_i (redirect_i.valid),
        .mem_req_o        (mem_req_o),
        .mem_ready_i      (mem_ready_i),
        .fill_o           (fill),
        .advance_o        (advance),
        .fetch_valid_o    (fetch_valid_o)
    );

    fetch_credit_counter #(
        .CREDITS (CREDITS)
    ) fetch_credit_counter_i (
        .clk            (clk),
        .rst            (rst),
        .consume_i      (fetch_valid_o),
        .return_i       (credit_return_i),
        .credit_avail_o (credit_avail)
    );

    // packet carries the lookup pc and its word
    assign fetch_o.pc    = pc;
    assign fetch_o.instr = instr;

endmodule : ifetch_top

`default_nettype wire

// File: ifetch_assertions.sv
////////////////////////////////////////
// protocol properties of the fetch top
// bound into ifetch_top by the bind below
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module ifetch_assertions
    import fetch_pkg::*;
    import mem_bus_pkg::*;
#(
    // decode buffer depth
    parameter int unsigned CREDITS = 2
) (
    input wire logic      clk,
    input wire logic      rst,
    input wire redirect_t redirect_i,
    input wire mem_req_t  mem_req_i,
    input wire logic      mem_ready_i,
    input wire logic      fetch_valid_i,
    input wire addr_t     fetch_pc_i,
    input wire logic      credit_return_i
);

    // free decode slots, seen only from the top level ports
    int free_slots;

    always_ff @(posedge clk) begin
        if (rst) begin
            free_slots <= CREDITS;
        end else begin
            free_slots <= free_slots - int'(fetch_valid_i) + int'(credit_return_i);
        end
    end

    // request held with a fixed address until memory takes it
    property req_held_until_ready;
        @(posedge clk) disable iff (rst)
        mem_req_i.valid && !mem_ready_i |=> mem_req_i.valid && $stable(mem_req_i.addr);
    endproperty

    // credit count zero means no packet
    property no_fetch_without_credit;
        @(posedge clk) disable iff (rst)
        fetch_valid_i |-> free_slots > 0;
    endproperty

    // no packet in the redirect cycle, lookup moves to the target next
    property no_fetch_on_redirect;
        @(posedge clk) disable iff (rst)
        redirect_i.valid |-> !fetch_valid_i ##1 fetch_pc_i == $past(redirect_i.target);
    endproperty

    req_held_a: assert property (req_held_until_ready)
        else $error("memory request dropped or changed before ready");
    credit_a: assert property (no_fetch_without_credit)
        else $error("packet sent while the credit count is zero");
    redirect_a: assert property (no_fetch_on_redirect)
        else $error("packet sent in a redirect cycle or pc not moved to the target");

endmodule : ifetch_assertions

bind ifetch_top ifetch_assertions #(
    .CREDITS (CREDITS)
) ifetch_assertions_i (
    .clk             (clk),
    .rst             (rst),
    .redirect_i      (redirect_i),
    .mem_req_i       (mem_req_o),
    .mem_ready_i     (mem_ready_i),
    .fetch_valid_i   (fetch_valid_o),
    .fetch_pc_i      (fetch_o.pc),
    .credit_return_i (credit_return_i)
);

`default_nettype wire

// File: ifetch_tb.sv
////////////////////////////////////////
// testbench for the fetch stage top
// drives reset, redirects and decode credits,
// models memory and checks every packet
////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module ifetch_tb
    import fetch_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int unsigned NUM_LINES = 16;
    localparam int unsigned CREDITS   = 2;

    // packets per phase
    localparam int SEQ_FETCHES      = 64;
    localparam int CREDIT_FETCHES   = 24;
    localparam int REDIRECT_ROUNDS  = 6;
    localparam int REDIRECT_FETCHES = 12;
    localparam int REUSE_FETCHES    = 40;
    localparam int PLANNED_FETCHES  = SEQ_FETCHES + CREDIT_FETCHES
                                    + REDIRECT_ROUNDS * REDIRECT_FETCHES + REUSE_FETCHES;
    localparam int TIMEOUT_CYCLES   = 20 * PLANNED_FETCHES;
    localparam int HOLD_CYCLES      = 40;

    // first fetch address of the core
    localparam addr_t BOOT_PC = 64'h0000_0000_8000_0000;

    // reuse regions, A on indices 0..3, B on 4..5
    localparam addr_t REUSE_A = 64'h0000_0000_8002_0000;
    localparam addr_t REUSE_B = 64'h0000_0000_8003_0040;

    logic       clk;
    logic       rst;
    redirect_t  redirect;
    logic       credit_return;
    fetch_pkt_t fetch;
    logic       fetch_valid;
    mem_req_t   mem_req;
    logic       mem_ready;
    line_t      mem_rdata;

    // checker state
    addr_t exp_pc;
    int    pkt_count;
    int    outstanding;
    int    cycle_count;

    // memory model state
    logic        busy;
    logic        just_done;
    logic        first_req;
    int          wait_cycles;
    addr_t       req_addr;
    logic [31:0] mem_seed;
    logic [55:0] model_tag [NUM_LINES];
    logic [NUM_LINES-1:0] model_valid;
    logic        revisit_active;
    int          revisit_reqs;

    // decode model state
    logic [31:0] dec_seed;
    logic [31:0] stim_seed;
    logic        hold_credits;
    int          stall_left;

    ifetch_top #(
        .NUM_LINES (NUM_LINES),
        .CREDITS   (CREDITS)
    ) dut_i (
        .clk             (clk),
        .rst             (rst),
        .redirect_i      (redirect),
        .credit_return_i (credit_return),
        .fetch_o         (fetch),
        .fetch_valid_o   (fetch_valid),
        .mem_req_o       (mem_req),
        .mem_ready_i     (mem_ready),
        .mem_rdata_i     (mem_rdata)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected memory contents, a hash of the word address
    function automatic instr_t mem_word(input addr_t addr);
        logic [31:0] x;
        x = addr[31:0] ^ addr[63:32];
        x = x ^ (x >> 15);
        x = x * 32'h2c1b_3c6d;
        x = x ^ (x >> 12);
        return x;
    endfunction

    // lowest address word in the low bits
    function automatic line_t build_line(input addr_t line_addr);
        line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = mem_word(line_addr + addr_t'(w * 4));
        end
        return line;
    endfunction

    task automatic report_failure(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic wait_packets(input int n);
        int target;
        target = pkt_count + n;
        while (pkt_count < target) begin
            @(negedge clk);
        end
    endtask

    // one cycle of redirect, starting at the current falling edge
    task automatic send_redirect(input addr_t target);
        redirect.valid  = 1'b1;
        redirect.target = target;
        @(negedge clk);
        redirect.valid  = 1'b0;
    endtask

    task automatic wait_refill();
        while (!mem_req.valid) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run timed out after %0d cycles", cycle_count);
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    // tracks the expected pc and the credits held by decode
    always @(posedge clk) begin
        if (rst) begin
            exp_pc      = BOOT_PC;
            pkt_count   = 0;
            outstanding = 0;
        end else begin
            if (fetch_valid) begin
                assert (!redirect.valid)
                    else report_failure("packet sent in a redirect cycle");
                assert (outstanding < CREDITS)
                    else report_failure("packet sent with no free decode credit");
                assert (fetch.pc == exp_pc)
                    else report_failure($sformatf("pc 0x%h, expected 0x%h", fetch.pc, exp_pc));
                assert (fetch.instr == mem_word(exp_pc))
                    else report_failure($sformatf("instr 0x%h at pc 0x%h, expected 0x%h",
                                                  fetch.instr, exp_pc, mem_word(exp_pc)));
                exp_pc = exp_pc + addr_t'(4);
                pkt_count++;
                outstanding++;
            end
            if (credit_return) begin
                outstanding--;
            end
            // redirect wins over the step
            if (redirect.valid) begin
                exp_pc = redirect.target;
            end
        end
    end

    // memory answers after 1 to 5 cycles
    always @(negedge clk) begin
        mem_ready = 1'b0;
        if (rst) begin
            busy        = 1'b0;
            just_done   = 1'b0;
            first_req   = 1'b1;
            model_valid = '0;
        end else begin
            if (just_done) begin
                assert (!mem_req.valid)
                    else report_failure("memory request still valid after the handshake");
            end
            just_done = 1'b0;
            if (busy) begin
                assert (mem_req.valid && mem_req.addr == req_addr)
                    else report_failure("memory request dropped or changed before ready");
            end else if (mem_req.valid) begin
                req_addr = mem_req.addr;
                assert (req_addr[3:0] == 4'h0)
                    else report_failure($sformatf("request 0x%h not line aligned", req_addr));
                if (first_req) begin
                    assert (req_addr == BOOT_PC)
                        else report_failure($sformatf("first request 0x%h", req_addr));
                end
                assert (!(model_valid[req_addr[7:4]] && model_tag[req_addr[7:4]] == req_addr[63:8]))
                    else report_failure($sformatf("request for cached line 0x%h", req_addr));
                model_valid[req_addr[7:4]] = 1'b1;
                model_tag[req_addr[7:4]]   = req_addr[63:8];
                if (revisit_active && req_addr >= REUSE_A && req_addr < REUSE_A + 64'h40) begin
                    revisit_reqs++;
                end
                first_req   = 1'b0;
                busy        = 1'b1;
                mem_seed    = lcg_next(mem_seed);
                wait_cycles = 1 + int'((mem_seed >> 16) % 5);
            end
            if (busy) begin
                if (wait_cycles <= 1) begin
                    mem_ready = 1'b1;
                    mem_rdata = build_line(req_addr);
                    busy      = 1'b0;
                    just_done = 1'b1;
                end else begin
                    wait_cycles--;
                end
            end
        end
    end

    // decode frees slots at random, with occasional long stalls
    always @(negedge clk) begin
        credit_return = 1'b0;
        dec_seed = lcg_next(dec_seed);
        if (!rst) begin
            if (stall_left > 0) begin
                stall_left--;
            end else if (dec_seed[31:26] == 6'd0) begin
                stall_left = 8 + int'(dec_seed[19:16]);
            end else if (!hold_credits && outstanding > 0 && dec_seed[24]) begin
                credit_return = 1'b1;
            end
        end
    end

    initial begin
        rst            = 1'b1;
        redirect       = '0;
        credit_return  = 1'b0;
        mem_ready      = 1'b0;
        mem_rdata      = '0;
        mem_seed       = 32'd80;
        dec_seed       = lcg_next(32'd80);
        stim_seed      = lcg_next(lcg_next(32'd80));
        hold_credits   = 1'b0;
        stall_left     = 0;
        revisit_active = 1'b0;
        revisit_reqs   = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset pc and a sequential run over several lines
        wait_packets(SEQ_FETCHES);

        // decode withholds credits, then lets go
        hold_credits = 1'b1;
        repeat (HOLD_CYCLES) @(negedge clk);
        hold_credits = 1'b0;
        wait_packets(CREDIT_FETCHES);

        // a miss region first, second redirect lands inside its refill
        for (int i = 0; i < REDIRECT_ROUNDS; i++) begin
            stim_seed = lcg_next(stim_seed);
            send_redirect(64'h8010_0000 + addr_t'(i * 32'h1000) + {stim_seed[9:2], 2'b00});
            wait_refill();
            stim_seed = lcg_next(stim_seed);
            send_redirect(64'h8000_0000 + {stim_seed[11:2], 2'b00});
            wait_packets(REDIRECT_FETCHES);
        end

        // visit A, then B, then A again with no refill of A
        send_redirect(REUSE_A);
        wait_packets(16);
        send_redirect(REUSE_B);
        wait_packets(8);
        revisit_active = 1'b1;
        send_redirect(REUSE_A);
        wait_packets(16);
        revisit_active = 1'b0;
        assert (revisit_reqs == 0)
            else report_failure("revisited lines were fetched from memory again");

        repeat (4) @(negedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule : ifetch_tb

`default_nettype wire

// File: ifetch.f
fetch_pkg.sv
mem_bus_pkg.sv
pc_gen.sv
icache_arrays.sv
icache_ctrl.sv
fetch_credit_counter.sv
ifetch_top.sv
ifetch_assertions.sv
ifetch_tb.sv

// File: Bender.yml
package:
  name: ifetch

sources:
  - fetch_pkg.sv
  - mem_bus_pkg.sv
  - pc_gen.sv
  - icache_arrays.sv
  - icache_ctrl.sv
  - fetch_credit_counter.sv
  - ifetch_top.sv
  - target: test
    files:
      - ifetch_assertions.sv
      - ifetch_tb.sv
